// ==== src/spmm_settings.svh ====
`ifndef SPMM_SETTINGS_SVH
`define SPMM_SETTINGS_SVH

// one processing element per weight column
`define SPMM_N_COLS      4
`define SPMM_DATA_W      8
`define SPMM_VALUE_W     8
`define SPMM_ACC_W       20

// sparse storage
`define SPMM_MAX_NNZ     64
`define SPMM_NNZ_ADDR_W  6
`define SPMM_W_ROWS      16
`define SPMM_COL_IDX_W   4
`define SPMM_MAX_ROWS    16
`define SPMM_ROW_ADDR_W  4
`define SPMM_ROW_LEN_W   6
`define SPMM_NUM_NODE_W  4

`define SPMM_FIFO_DEPTH  4

`endif

// ==== src/spmm_pkg.sv ====
`include "spmm_settings.svh"

package spmm_pkg;

  // per-row info word as stored in the node-info memory
  typedef struct packed {
    logic [`SPMM_ROW_LEN_W-1:0]  row_len;
    logic [`SPMM_NUM_NODE_W-1:0] num_nodes;
    logic                        src_flag;
  } node_info_t;

  // load port target
  typedef enum logic [1:0] {
    MEM_COL_IDX   = 2'd0,
    MEM_VALUE     = 2'd1,
    MEM_NODE_INFO = 2'd2,
    MEM_WEIGHT    = 2'd3
  } mem_sel_t;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2,
    ST_DONE  = 2'd3
  } sched_state_t;

  typedef logic signed [`SPMM_ACC_W-1:0] acc_t;

endpackage

// ==== src/pe_bus_if.sv ====
`timescale 1ns/1ps
`include "spmm_settings.svh"

// one nonzero broadcast to every processing element
interface pe_bus_if;

  logic                        valid;
  logic [`SPMM_COL_IDX_W-1:0]  col_idx;
  logic [`SPMM_VALUE_W-1:0]    value;
  // nonzero closes its row
  logic                        last;

  modport sched (
    output valid,
    output col_idx,
    output value,
    output last
  );

  // no ready, every element takes one nonzero per cycle
  modport pe (
    input valid,
    input col_idx,
    input value,
    input last
  );

endinterface

// ==== src/node_info_fifo.sv ====
`timescale 1ns/1ps
`include "spmm_settings.svh"

module node_info_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_en_i,
  input  spmm_pkg::node_info_t data_i,
  input  logic                 rd_en_i,
  output spmm_pkg::node_info_t data_o,
  output logic                 empty_o,
  output logic                 full_o
);
  import spmm_pkg::*;

  localparam int DEPTH = `SPMM_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  node_info_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en_i) - CNT_W'(rd_en_i);
    end
  end

  // head visible without a read cycle
  assign data_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(DEPTH));

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    full_o |-> !wr_en_i)
    else $error("node info fifo pushed while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    empty_o |-> !rd_en_i)
    else $error("node info fifo popped while empty");

endmodule

// ==== src/sp_pe.sv ====
`timescale 1ns/1ps
`include "spmm_settings.svh"

module sp_pe (
  input  logic                        clk,
  input  logic                        rst_n,
  pe_bus_if.pe                        bus,
  input  logic                        w_we_i,
  input  logic [`SPMM_COL_IDX_W-1:0]  w_addr_i,
  input  logic [`SPMM_DATA_W-1:0]     w_data_i,
  output logic                        row_done_o,
  output spmm_pkg::acc_t              sum_o
);
  import spmm_pkg::*;

  // this element's weight column
  logic [`SPMM_DATA_W-1:0] w_mem [`SPMM_W_ROWS];

  logic signed [`SPMM_DATA_W-1:0]  w_q;
  logic signed [`SPMM_VALUE_W-1:0] v_q;
  logic                            vld_q;
  logic                            last_q;
  acc_t                            acc;
  acc_t                            prod;
  acc_t                            acc_sum;

  always_ff @(posedge clk) begin
    if (w_we_i) begin
      w_mem[w_addr_i] <= w_data_i;
    end
  end

  // stage 1, weight lookup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q  <= 1'b0;
      last_q <= 1'b0;
    end else begin
      vld_q  <= bus.valid;
      last_q <= bus.valid && bus.last;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.valid) begin
      w_q <= w_mem[bus.col_idx];
      v_q <= bus.value;
    end
  end

  // operands sign extended to the accumulator width
  always_comb begin
    prod    = v_q * w_q;
    acc_sum = acc + prod;
  end

  // stage 2, accumulate
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc        <= '0;
      row_done_o <= 1'b0;
    end else begin
      row_done_o <= vld_q && last_q;
      if (vld_q) begin
        acc <= last_q ? '0 : acc_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vld_q && last_q) begin
      sum_o <= acc_sum;
    end
  end

  // weights only change while no nonzero is in the pipeline
  a_no_weight_wr_busy: assert property (@(posedge clk) disable iff (!rst_n)
    w_we_i |-> !bus.valid && !vld_q)
    else $error("weight written during a run");

endmodule

// ==== src/h_matrix_store.sv ====
`timescale 1ns/1ps
`include "spmm_settings.svh"

module h_matrix_store (
  input  logic                                   clk,
  input  logic                                   load_we_i,
  input  spmm_pkg::mem_sel_t                     load_sel_i,
  input  logic [`SPMM_NNZ_ADDR_W-1:0]            load_addr_i,
  input  logic [$bits(spmm_pkg::node_info_t)-1:0] load_data_i,
  input  logic [`SPMM_NNZ_ADDR_W-1:0]            nnz_addr_i,
  output logic [`SPMM_COL_IDX_W-1:0]             col_idx_o,
  output logic [`SPMM_VALUE_W-1:0]               value_o,
  input  logic [`SPMM_ROW_ADDR_W-1:0]            row_addr_i,
  output spmm_pkg::node_info_t                   node_info_o
);
  import spmm_pkg::*;

  logic [`SPMM_COL_IDX_W-1:0] col_idx_mem [`SPMM_MAX_NNZ];
  logic [`SPMM_VALUE_W-1:0]   value_mem   [`SPMM_MAX_NNZ];
  node_info_t                 info_mem    [`SPMM_MAX_ROWS];

  logic we_col_idx;
  logic we_value;
  logic we_info;

  // weight loads go to the processing elements
  always_comb begin
    we_col_idx = load_we_i && (load_sel_i == MEM_COL_IDX);
    we_value   = load_we_i && (load_sel_i == MEM_VALUE);
    we_info    = load_we_i && (load_sel_i == MEM_NODE_INFO);
  end

  always_ff @(posedge clk) begin
    if (we_col_idx) begin
      col_idx_mem[load_addr_i] <= load_data_i[`SPMM_COL_IDX_W-1:0];
    end
    if (we_value) begin
      value_mem[load_addr_i] <= load_data_i[`SPMM_VALUE_W-1:0];
    end
    if (we_info) begin
      info_mem[load_addr_i[`SPMM_ROW_ADDR_W-1:0]] <= node_info_t'(load_data_i);
    end
  end

  // registered reads, one cycle latency
  always_ff @(posedge clk) begin
    col_idx_o   <= col_idx_mem[nnz_addr_i];
    value_o     <= value_mem[nnz_addr_i];
    node_info_o <= info_mem[row_addr_i];
  end

endmodule

// ==== src/spmm_scheduler.sv ====
`timescale 1ns/1ps
`include "spmm_settings.svh"

module spmm_scheduler (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      start_req_i,
  input  logic [`SPMM_ROW_ADDR_W:0]                 num_rows_i,
  output logic                                      start_ack_o,
  output logic [`SPMM_NNZ_ADDR_W-1:0]               nnz_addr_o,
  input  logic [`SPMM_COL_IDX_W-1:0]                col_idx_i,
  input  logic [`SPMM_VALUE_W-1:0]                  value_i,
  output logic [`SPMM_ROW_ADDR_W-1:0]               row_addr_o,
  input  spmm_pkg::node_info_t                      node_info_i,
  pe_bus_if.sched                                   bus,
  input  logic [`SPMM_N_COLS-1:0]                   row_done_i,
  input  spmm_pkg::acc_t [`SPMM_N_COLS-1:0]         sums_i,
  output logic                                      res_valid_o,
  output spmm_pkg::acc_t [`SPMM_N_COLS-1:0]         res_sums_o,
  output logic [`SPMM_NUM_NODE_W-1:0]               res_num_nodes_o,
  output logic                                      res_src_flag_o,
  output logic [`SPMM_ROW_ADDR_W-1:0]               res_row_o,
  output logic                                      busy_o
);
  import spmm_pkg::*;

  sched_state_t                state;
  logic [`SPMM_ROW_ADDR_W:0]   num_rows_q;
  logic [`SPMM_ROW_ADDR_W:0]   next_row;
  logic [`SPMM_ROW_ADDR_W:0]   out_row;
  logic [`SPMM_ROW_LEN_W-1:0]  rem;
  logic [`SPMM_ROW_LEN_W-1:0]  cur_len;
  logic [`SPMM_NNZ_ADDR_W-1:0] nnz_ptr;
  logic                        row_start;
  logic                        issue;
  logic                        issue_last;
  logic                        ff_full;
  logic                        ff_pop;
  node_info_t                  ff_head;

  // node_info_i always holds the entry of next_row while running
  always_comb begin
    row_start  = (state == ST_RUN) && (rem == '0) && (next_row < num_rows_q) && !ff_full;
    issue      = row_start || ((state == ST_RUN) && (rem != '0));
    cur_len    = row_start ? node_info_i.row_len : rem;
    issue_last = issue && (cur_len == `SPMM_ROW_LEN_W'(1));
  end

  // prefetch the following row as soon as this one starts
  assign row_addr_o = row_start ? next_row[`SPMM_ROW_ADDR_W-1:0] + 1'b1
                                : next_row[`SPMM_ROW_ADDR_W-1:0];
  assign nnz_addr_o = nnz_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      num_rows_q <= '0;
      next_row   <= '0;
      rem        <= '0;
      nnz_ptr    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start_req_i) begin
            num_rows_q <= num_rows_i;
            next_row   <= '0;
            rem        <= '0;
            nnz_ptr    <= '0;
            state      <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (issue) begin
            nnz_ptr <= nnz_ptr + 1'b1;
            rem     <= cur_len - 1'b1;
          end
          if (row_start) begin
            next_row <= next_row + 1'b1;
          end
          if ((rem == '0) && (next_row == num_rows_q)) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (out_row == num_rows_q) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (!start_req_i) begin
            next_row <= '0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // memory data arrives one cycle after the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.valid <= 1'b0;
      bus.last  <= 1'b0;
    end else begin
      bus.valid <= issue;
      bus.last  <= issue_last;
    end
  end

  assign bus.col_idx = col_idx_i;
  assign bus.value   = value_i;

  node_info_fifo u_info_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en_i (row_start),
    .data_i  (node_info_i),
    .rd_en_i (ff_pop),
    .data_o  (ff_head),
    .empty_o (),
    .full_o  (ff_full)
  );

  // element 0 speaks for all columns
  assign ff_pop = row_done_i[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
      out_row     <= '0;
    end else begin
      res_valid_o <= ff_pop;
      if (state == ST_IDLE) begin
        out_row <= '0;
      end else if (ff_pop) begin
        out_row <= out_row + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ff_pop) begin
      res_sums_o      <= sums_i;
      res_num_nodes_o <= ff_head.num_nodes;
      res_src_flag_o  <= ff_head.src_flag;
      res_row_o       <= out_row[`SPMM_ROW_ADDR_W-1:0];
    end
  end

  assign start_ack_o = (state == ST_DONE);
  assign busy_o      = (state != ST_IDLE);

  a_pe_agree: assert property (@(posedge clk) disable iff (!rst_n)
    (row_done_i == '0) || (row_done_i == '1))
    else $error("processing elements disagree on row_done");

endmodule

// ==== src/spmm_top.sv ====
`timescale 1ns/1ps
`include "spmm_settings.svh"

module spmm_top (
  input  logic                                    clk,
  input  logic                                    rst_n,
  // load port
  input  logic                                    load_we_i,
  input  spmm_pkg::mem_sel_t                      load_sel_i,
  input  logic [$clog2(`SPMM_N_COLS)-1:0]         load_col_i,
  input  logic [`SPMM_NNZ_ADDR_W-1:0]             load_addr_i,
  input  logic [$bits(spmm_pkg::node_info_t)-1:0] load_data_i,
  // run handshake
  input  logic                                    start_req_i,
  input  logic [`SPMM_ROW_ADDR_W:0]               num_rows_i,
  output logic                                    start_ack_o,
  // results
  output logic                                    res_valid_o,
  output spmm_pkg::acc_t [`SPMM_N_COLS-1:0]       res_sums_o,
  output logic [`SPMM_NUM_NODE_W-1:0]             res_num_nodes_o,
  output logic                                    res_src_flag_o,
  output logic [`SPMM_ROW_ADDR_W-1:0]             res_row_o
);
  import spmm_pkg::*;

  localparam int COL_SEL_W = $clog2(`SPMM_N_COLS);

  logic [`SPMM_NNZ_ADDR_W-1:0]  nnz_addr;
  logic [`SPMM_COL_IDX_W-1:0]   col_idx;
  logic [`SPMM_VALUE_W-1:0]     value;
  logic [`SPMM_ROW_ADDR_W-1:0]  row_addr;
  node_info_t                   node_info;
  logic                         busy;
  logic                         load_ok;
  logic [`SPMM_N_COLS-1:0]      w_we;
  logic [`SPMM_N_COLS-1:0]      row_done;
  acc_t [`SPMM_N_COLS-1:0]      sums;

  pe_bus_if pe_bus ();

  // loads only land while idle
  assign load_ok = load_we_i && !busy;

  h_matrix_store u_store (
    .clk         (clk),
    .load_we_i   (load_ok),
    .load_sel_i  (load_sel_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .nnz_addr_i  (nnz_addr),
    .col_idx_o   (col_idx),
    .value_o     (value),
    .row_addr_i  (row_addr),
    .node_info_o (node_info)
  );

  spmm_scheduler u_sched (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_req_i     (start_req_i),
    .num_rows_i      (num_rows_i),
    .start_ack_o     (start_ack_o),
    .nnz_addr_o      (nnz_addr),
    .col_idx_i       (col_idx),
    .value_i         (value),
    .row_addr_o      (row_addr),
    .node_info_i     (node_info),
    .bus             (pe_bus.sched),
    .row_done_i      (row_done),
    .sums_i          (sums),
    .res_valid_o     (res_valid_o),
    .res_sums_o      (res_sums_o),
    .res_num_nodes_o (res_num_nodes_o),
    .res_src_flag_o  (res_src_flag_o),
    .res_row_o       (res_row_o),
    .busy_o          (busy)
  );

  for (genvar i = 0; i < `SPMM_N_COLS; i++) begin : g_pe
    assign w_we[i] = load_ok && (load_sel_i == MEM_WEIGHT) &&
                     (load_col_i == COL_SEL_W'(i));

    sp_pe u_pe (
      .clk        (clk),
      .rst_n      (rst_n),
      .bus        (pe_bus.pe),
      .w_we_i     (w_we[i]),
      .w_addr_i   (load_addr_i[`SPMM_COL_IDX_W-1:0]),
      .w_data_i   (load_data_i[`SPMM_DATA_W-1:0]),
      .row_done_o (row_done[i]),
      .sum_o      (sums[i])
    );
  end

  a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
    load_we_i |-> !busy)
    else $error("load attempted while a run is active");

endmodule

// ==== dv/tb_spmm_cases.svh ====
`ifndef TB_SPMM_CASES_SVH
`define TB_SPMM_CASES_SVH

// per case: source (0 table, 1 random), random rows, max random row length,
// weight style (0 ascending, 1 signed pattern, 2 random)
localparam int N_CASES = 5;
localparam int CASE_TAB [N_CASES][4] = '{
  '{0, 0, 0, 0},
  '{0, 0, 0, 0},
  '{1, 16, 2, 2},
  '{0, 0, 0, 1},
  '{1, 6, 5, 2}
};

// per row of a table case: case, num_nodes, src_flag
localparam int ROW_TAB_LEN = 7;
localparam int ROW_TAB [ROW_TAB_LEN][3] = '{
  '{0, 3, 1},
  '{1, 1, 0}, '{1, 3, 1}, '{1, 2, 0}, '{1, 7, 1},
  '{3, 2, 1}, '{3, 15, 0}
};

// nonzeros in storage order: case, row, col_idx, value
localparam int NZ_TAB_LEN = 16;
localparam int NZ_TAB [NZ_TAB_LEN][4] = '{
  '{0, 0, 5, 3},
  '{1, 0, 2, 7},
  '{1, 1, 0, 1}, '{1, 1, 7, -2}, '{1, 1, 15, 4},
  '{1, 2, 9, 11},
  '{1, 3, 1, 2}, '{1, 3, 3, -1}, '{1, 3, 4, 5}, '{1, 3, 12, 6}, '{1, 3, 14, 1},
  // extremes of the value range
  '{3, 0, 3, -128}, '{3, 0, 10, -7},
  '{3, 1, 0, -1}, '{3, 1, 6, -100}, '{3, 1, 15, 127}
};

`endif

// ==== dv/tb_spmm.sv ====
`timescale 1ns/1ps
`include "spmm_settings.svh"

module tb_spmm;
  import spmm_pkg::*;

  localparam int COL_SEL_W   = $clog2(`SPMM_N_COLS);
  localparam int INFO_W      = $bits(node_info_t);
  localparam int RUN_TIMEOUT = 1000;
  localparam int ACK_TIMEOUT = 20;

  `include "tb_spmm_cases.svh"

  logic                            clk;
  logic                            rst_n;
  logic                            load_we_i;
  mem_sel_t                        load_sel_i;
  logic [COL_SEL_W-1:0]            load_col_i;
  logic [`SPMM_NNZ_ADDR_W-1:0]     load_addr_i;
  logic [INFO_W-1:0]               load_data_i;
  logic                            start_req_i;
  logic [`SPMM_ROW_ADDR_W:0]       num_rows_i;
  logic                            start_ack_o;
  logic                            res_valid_o;
  acc_t [`SPMM_N_COLS-1:0]         res_sums_o;
  logic [`SPMM_NUM_NODE_W-1:0]     res_num_nodes_o;
  logic                            res_src_flag_o;
  logic [`SPMM_ROW_ADDR_W-1:0]     res_row_o;

  // current case
  integer                          seed = 32'h3af883a9;
  int                              n_rows;
  int                              n_nz;
  node_info_t                      row_info [`SPMM_MAX_ROWS];
  logic [`SPMM_COL_IDX_W-1:0]      nz_col   [`SPMM_MAX_NNZ];
  logic signed [`SPMM_VALUE_W-1:0] nz_val   [`SPMM_MAX_NNZ];
  logic signed [`SPMM_DATA_W-1:0]  w        [`SPMM_W_ROWS][`SPMM_N_COLS];
  acc_t                            want_sums [`SPMM_MAX_ROWS][`SPMM_N_COLS];

  spmm_top dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .load_we_i       (load_we_i),
    .load_sel_i      (load_sel_i),
    .load_col_i      (load_col_i),
    .load_addr_i     (load_addr_i),
    .load_data_i     (load_data_i),
    .start_req_i     (start_req_i),
    .num_rows_i      (num_rows_i),
    .start_ack_o     (start_ack_o),
    .res_valid_o     (res_valid_o),
    .res_sums_o      (res_sums_o),
    .res_num_nodes_o (res_num_nodes_o),
    .res_src_flag_o  (res_src_flag_o),
    .res_row_o       (res_row_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_error(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_sum(input int col, input acc_t got, input acc_t want);
    if (got !== want) begin
      report_error($sformatf("** Error at %0t: res_sums_o[%0d] = %0d, expected %0d",
                             $time, col, got, want));
    end
  endtask

  task automatic check_node_info(input node_info_t got, input node_info_t want);
    if (got.num_nodes !== want.num_nodes) begin
      report_error($sformatf("** Error at %0t: res_num_nodes_o = %0d, expected %0d",
                             $time, got.num_nodes, want.num_nodes));
    end
    if (got.src_flag !== want.src_flag) begin
      report_error($sformatf("** Error at %0t: res_src_flag_o = %0b, expected %0b",
                             $time, got.src_flag, want.src_flag));
    end
  endtask

  task automatic check_row(input logic [`SPMM_ROW_ADDR_W-1:0] got,
                           input logic [`SPMM_ROW_ADDR_W-1:0] want);
    if (got !== want) begin
      report_error($sformatf("** Error at %0t: res_row_o = %0d, expected %0d",
                             $time, got, want));
    end
  endtask

  task automatic build_case(input int c);
    int i;
    int r;
    int j;
    int len;
    int idx;
    int rnd;
    n_rows = 0;
    n_nz   = 0;
    if (CASE_TAB[c][0] == 0) begin
      for (i = 0; i < ROW_TAB_LEN; i++) begin
        if (ROW_TAB[i][0] == c) begin
          row_info[n_rows].row_len   = '0;
          row_info[n_rows].num_nodes = `SPMM_NUM_NODE_W'(ROW_TAB[i][1]);
          row_info[n_rows].src_flag  = (ROW_TAB[i][2] != 0);
          n_rows++;
        end
      end
      for (i = 0; i < NZ_TAB_LEN; i++) begin
        if (NZ_TAB[i][0] == c) begin
          r = NZ_TAB[i][1];
          row_info[r].row_len = row_info[r].row_len + 1'b1;
          nz_col[n_nz] = `SPMM_COL_IDX_W'(NZ_TAB[i][2]);
          nz_val[n_nz] = `SPMM_VALUE_W'(NZ_TAB[i][3]);
          n_nz++;
        end
      end
    end else begin
      n_rows = CASE_TAB[c][1];
      for (r = 0; r < n_rows; r++) begin
        len = 1 + ({$random(seed)} % CASE_TAB[c][2]);
        rnd = $random(seed);
        row_info[r].row_len   = `SPMM_ROW_LEN_W'(len);
        row_info[r].num_nodes = rnd[`SPMM_NUM_NODE_W-1:0];
        row_info[r].src_flag  = rnd[8];
        for (i = 0; i < len; i++) begin
          rnd = $random(seed);
          nz_col[n_nz] = rnd[`SPMM_COL_IDX_W-1:0];
          nz_val[n_nz] = rnd[15:8];
          n_nz++;
        end
      end
    end
    // fill uses row and column together
    for (r = 0; r < `SPMM_W_ROWS; r++) begin
      for (j = 0; j < `SPMM_N_COLS; j++) begin
        idx = r * `SPMM_N_COLS + j;
        case (CASE_TAB[c][3])
          0: w[r][j] = `SPMM_DATA_W'(idx + 1);
          1: w[r][j] = (idx % 2 == 1) ? `SPMM_DATA_W'(-idx) : `SPMM_DATA_W'(idx - 50);
          default: begin
            rnd = $random(seed);
            w[r][j] = rnd[`SPMM_DATA_W-1:0];
          end
        endcase
      end
    end
  endtask

  // sum over the row of value times W[col_idx][j]
  task automatic compute_expected();
    int r;
    int i;
    int j;
    int p;
    acc_t a;
    acc_t b;
    p = 0;
    for (r = 0; r < n_rows; r++) begin
      for (j = 0; j < `SPMM_N_COLS; j++) begin
        want_sums[r][j] = '0;
        for (i = 0; i < int'(row_info[r].row_len); i++) begin
          a = nz_val[p + i];
          b = w[nz_col[p + i]][j];
          want_sums[r][j] = want_sums[r][j] + a * b;
        end
      end
      p = p + int'(row_info[r].row_len);
    end
  endtask

  task automatic write_mem(input mem_sel_t sel, input int col, input int addr,
                           input logic [INFO_W-1:0] data);
    @(posedge clk);
    load_we_i   <= 1'b1;
    load_sel_i  <= sel;
    load_col_i  <= COL_SEL_W'(col);
    load_addr_i <= `SPMM_NNZ_ADDR_W'(addr);
    load_data_i <= data;
  endtask

  task automatic load_case();
    int i;
    int r;
    int j;
    for (i = 0; i < n_nz; i++) begin
      write_mem(MEM_COL_IDX, 0, i, INFO_W'(nz_col[i]));
      write_mem(MEM_VALUE, 0, i, INFO_W'($unsigned(nz_val[i])));
    end
    for (r = 0; r < n_rows; r++) begin
      write_mem(MEM_NODE_INFO, 0, r, row_info[r]);
    end
    for (r = 0; r < `SPMM_W_ROWS; r++) begin
      for (j = 0; j < `SPMM_N_COLS; j++) begin
        write_mem(MEM_WEIGHT, j, r, INFO_W'($unsigned(w[r][j])));
      end
    end
    @(posedge clk);
    load_we_i <= 1'b0;
  endtask

  task automatic check_result(input int k);
    node_info_t got;
    int j;
    check_row(res_row_o, `SPMM_ROW_ADDR_W'(k));
    for (j = 0; j < `SPMM_N_COLS; j++) begin
      check_sum(j, res_sums_o[j], want_sums[k][j]);
    end
    got.row_len   = row_info[k].row_len;
    got.num_nodes = res_num_nodes_o;
    got.src_flag  = res_src_flag_o;
    check_node_info(got, row_info[k]);
  endtask

  task automatic run_case();
    int k;
    int t;
    @(posedge clk);
    start_req_i <= 1'b1;
    num_rows_i  <= (`SPMM_ROW_ADDR_W + 1)'(n_rows);
    k = 0;
    for (t = 0; t < RUN_TIMEOUT && start_ack_o !== 1'b1; t++) begin
      @(negedge clk);
      if (res_valid_o === 1'b1) begin
        if (k >= n_rows) begin
          report_error($sformatf("more results than the %0d rows of the run", n_rows));
        end
        check_result(k);
        k++;
      end
    end
    if (start_ack_o !== 1'b1) begin
      report_error("timeout waiting for start_ack_o to rise");
    end
    if (k != n_rows) begin
      report_error($sformatf("start_ack_o rose after %0d of %0d results", k, n_rows));
    end
    // ack holds while req is still high
    repeat (2) begin
      @(negedge clk);
      if (start_ack_o !== 1'b1) begin
        report_error("start_ack_o fell while start_req_i was still high");
      end
      if (res_valid_o !== 1'b0) begin
        report_error("a result came out after start_ack_o");
      end
    end
    @(posedge clk);
    start_req_i <= 1'b0;
    for (t = 0; t < ACK_TIMEOUT && start_ack_o !== 1'b0; t++) begin
      @(negedge clk);
      if (res_valid_o !== 1'b0) begin
        report_error("a result came out during the end of the handshake");
      end
    end
    if (start_ack_o !== 1'b0) begin
      report_error("timeout waiting for start_ack_o to fall");
    end
  endtask

  initial begin
    int c;
    rst_n       = 1'b0;
    load_we_i   = 1'b0;
    load_sel_i  = MEM_COL_IDX;
    load_col_i  = '0;
    load_addr_i = '0;
    load_data_i = '0;
    start_req_i = 1'b0;
    num_rows_i  = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (res_valid_o !== 1'b0 || start_ack_o !== 1'b0) begin
      report_error("res_valid_o or start_ack_o not low after reset");
    end
    for (c = 0; c < N_CASES; c++) begin
      build_case(c);
      compute_expected();
      $display("case %0d: %0d rows, %0d nonzeros", c, n_rows, n_nz);
      load_case();
      run_case();
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
+incdir+dv
src/spmm_pkg.sv
src/pe_bus_if.sv
src/node_info_fifo.sv
src/sp_pe.sv
src/h_matrix_store.sv
src/spmm_scheduler.sv
src/spmm_top.sv
dv/tb_spmm.sv

// ==== Bender.yml ====
package:
  name: spmm

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/spmm_pkg.sv
      - src/pe_bus_if.sv
      - src/node_info_fifo.sv
      - src/sp_pe.sv
      - src/h_matrix_store.sv
      - src/spmm_scheduler.sv
      - src/spmm_top.sv
  - target: test
    include_dirs:
      - src
      - dv
    files:
      - dv/tb_spmm.sv
